/* hw/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes still decoded
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic {
        src_rs2,
        src_imm
    } src_b_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_imm   // lui result
    } wb_sel_e;

    typedef enum logic [2:0] {
        br_none,
        beq,
        bne,
        blt,
        bge
    } br_e;

    // source of an execute operand
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_e;

    typedef struct packed {
        alu_op_e   alu_op;
        src_b_e    src_b;
        wb_sel_e   wb_sel;
        br_e       br;
        logic      mem_read;
        logic      mem_write;
        logic      load_regfile;
        reg_addr_t rd;
        reg_addr_t rs1;   // zero when the instruction has no rs1
        reg_addr_t rs2;   // zero when the instruction has no rs2
        word_t     imm;
    } ctrl_word_t;

    // bubble, touches nothing
    localparam ctrl_word_t ctrl_nop = '{
        alu_op:       alu_add,
        src_b:        src_rs2,
        wb_sel:       wb_alu,
        br:           br_none,
        mem_read:     1'b0,
        mem_write:    1'b0,
        load_regfile: 1'b0,
        rd:           '0,
        rs1:          '0,
        rs2:          '0,
        imm:          '0
    };

endpackage

/* hw/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::word_t      instr,
    output rv_pkg::ctrl_word_t ctrl
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};

    always_comb begin
        ctrl = ctrl_nop;   // unknown opcodes stay a bubble
        case (opcode)
            op_lui: begin
                ctrl.wb_sel       = wb_imm;
                ctrl.load_regfile = 1'b1;
                ctrl.rd           = instr[11:7];
                ctrl.imm          = imm_u;
            end
            op_imm: begin
                // srai is the only immediate op with bit 30 meaning anything
                ctrl.alu_op       = alu_sel(funct3, (funct3 == 3'b101) && funct7_5);
                ctrl.src_b        = src_imm;
                ctrl.load_regfile = 1'b1;
                ctrl.rd           = instr[11:7];
                ctrl.rs1          = instr[19:15];
                ctrl.imm          = imm_i;
            end
            op_reg: begin
                ctrl.alu_op       = alu_sel(funct3, funct7_5);
                ctrl.load_regfile = 1'b1;
                ctrl.rd           = instr[11:7];
                ctrl.rs1          = instr[19:15];
                ctrl.rs2          = instr[24:20];
            end
            op_load: begin
                if (funct3 == 3'b010) begin   // lw only
                    ctrl.src_b        = src_imm;
                    ctrl.wb_sel       = wb_mem;
                    ctrl.mem_read     = 1'b1;
                    ctrl.load_regfile = 1'b1;
                    ctrl.rd           = instr[11:7];
                    ctrl.rs1          = instr[19:15];
                    ctrl.imm          = imm_i;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin   // sw only
                    ctrl.src_b     = src_imm;
                    ctrl.mem_write = 1'b1;
                    ctrl.rs1       = instr[19:15];
                    ctrl.rs2       = instr[24:20];
                    ctrl.imm       = imm_s;
                end
            end
            op_br: begin
                case (funct3)
                    3'b000:  ctrl.br = beq;
                    3'b001:  ctrl.br = bne;
                    3'b100:  ctrl.br = blt;
                    3'b101:  ctrl.br = bge;
                    default: ctrl.br = br_none;
                endcase
                if (ctrl.br != br_none) begin
                    ctrl.rs1 = instr[19:15];
                    ctrl.rs2 = instr[24:20];
                    ctrl.imm = imm_b;
                end
            end
            default: ctrl = ctrl_nop;
        endcase
    end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [0:31];   // entry 0 is never written
    logic  wr_en;

    assign wr_en = we && (rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wdata;
        end
    end

    // same-cycle write shows through, covers the wb to id distance
    assign rdata1 = (wr_en && (rd == rs1)) ? wdata : regs[rs1];
    assign rdata2 = (wr_en && (rd == rs2)) ? wdata : regs[rs2];

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::ctrl_word_t ctrl,
    input  rv_pkg::word_t      pc,
    input  rv_pkg::word_t      rs1_val,
    input  rv_pkg::word_t      rs2_val,
    input  rv_pkg::word_t      mem_val,
    input  rv_pkg::word_t      wb_val,
    input  rv_pkg::fwd_e       fwd_a,
    input  rv_pkg::fwd_e       fwd_b,
    output rv_pkg::word_t      alu_out,
    output rv_pkg::word_t      store_data,
    output logic               br_taken,
    output rv_pkg::word_t      br_target
);
    import rv_pkg::*;

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;

    function automatic word_t fwd_pick(fwd_e sel, word_t reg_v, word_t mem_v, word_t wb_v);
        case (sel)
            fwd_mem: return mem_v;
            fwd_wb:  return wb_v;
            default: return reg_v;
        endcase
    endfunction

    assign op_a    = fwd_pick(fwd_a, rs1_val, mem_val, wb_val);
    assign rs2_fwd = fwd_pick(fwd_b, rs2_val, mem_val, wb_val);
    assign op_b    = (ctrl.src_b == src_imm) ? ctrl.imm : rs2_fwd;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_xor:  alu_out = op_a ^ op_b;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            default:  alu_out = op_a + op_b;   // add, also load/store address
        endcase
    end

    // branches always compare the two registers, never the immediate
    always_comb begin
        case (ctrl.br)
            beq:     br_taken = (op_a == rs2_fwd);
            bne:     br_taken = (op_a != rs2_fwd);
            blt:     br_taken = ($signed(op_a) < $signed(rs2_fwd));
            bge:     br_taken = ($signed(op_a) >= $signed(rs2_fwd));
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target  = pc + ctrl.imm;
    assign store_data = rs2_fwd;   // forwarded, so a fresh result can be stored

endmodule

/* hw/rv_hazard.sv */
`timescale 1ns/10ps

module rv_hazard (
    input  rv_pkg::ctrl_word_t id_ctrl,
    input  rv_pkg::ctrl_word_t ex_ctrl,
    input  rv_pkg::ctrl_word_t mem_ctrl,
    input  rv_pkg::ctrl_word_t wb_ctrl,
    input  logic               br_taken_mem,
    output rv_pkg::fwd_e       fwd_a,
    output rv_pkg::fwd_e       fwd_b,
    output logic               stall,
    output logic               flush
);
    import rv_pkg::*;

    logic load_use;

    // producer writes a nonzero register that the consumer reads
    function automatic logic writes(ctrl_word_t producer, reg_addr_t rs);
        return producer.load_regfile && (producer.rd != '0) && (producer.rd == rs);
    endfunction

    function automatic fwd_e fwd_src(reg_addr_t rs);
        // loads in mem are kept out by the stall
        if (writes(mem_ctrl, rs) && !mem_ctrl.mem_read) begin
            return fwd_mem;
        end
        if (writes(wb_ctrl, rs)) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    assign fwd_a = fwd_src(ex_ctrl.rs1);
    assign fwd_b = fwd_src(ex_ctrl.rs2);

    assign load_use = ex_ctrl.mem_read &&
                      (writes(ex_ctrl, id_ctrl.rs1) || writes(ex_ctrl, id_ctrl.rs2));

    assign flush = br_taken_mem && (mem_ctrl.br != br_none);
    assign stall = load_use && !flush;   // a flush drops the pair anyway

endmodule

/* hw/rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::word_t inst_rdata,
    input  logic          inst_resp,
    output rv_pkg::word_t inst_addr,
    input  rv_pkg::word_t data_rdata,
    input  logic          data_resp,
    output rv_pkg::word_t data_addr,
    output rv_pkg::word_t data_wdata,
    output logic          data_read,
    output logic          data_write
);
    import rv_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t rs1_val;
        word_t rs2_val;
    } id_ex_t;

    typedef struct packed {
        word_t alu;
        word_t store_data;
        word_t br_target;
    } ex_mem_t;

    typedef struct packed {
        word_t alu;
        word_t rdata;
    } mem_wb_t;

    word_t      pc;
    word_t      pc_next;
    word_t      if_pc;
    word_t      if_instr;
    ctrl_word_t id_ctrl;
    ctrl_word_t ex_ctrl;
    ctrl_word_t mem_ctrl;
    ctrl_word_t wb_ctrl;
    id_ex_t     ex_data;
    ex_mem_t    mem_data;
    mem_wb_t    wb_data;
    logic       mem_br_taken;

    word_t rs1_val;
    word_t rs2_val;
    word_t alu_out;
    word_t store_data;
    word_t br_target;
    logic  br_taken;
    word_t mem_val;
    word_t wb_val;
    fwd_e  fwd_a;
    fwd_e  fwd_b;
    logic  stall;
    logic  flush;
    logic  data_active;
    logic  advance;

    // whole pipeline freezes until both memories have answered
    assign data_active = mem_ctrl.mem_read || mem_ctrl.mem_write;
    assign advance     = inst_resp && (!data_active || data_resp);

    always_comb begin
        if (flush) begin
            pc_next = mem_data.br_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= RESET_PC;
            if_instr     <= '0;   // decodes as a bubble
            ex_ctrl      <= ctrl_nop;
            mem_ctrl     <= ctrl_nop;
            wb_ctrl      <= ctrl_nop;
            mem_br_taken <= 1'b0;
        end else if (advance) begin
            pc <= pc_next;
            if (flush) begin
                if_instr <= '0;
            end else if (!stall) begin
                if_instr <= inst_rdata;
            end
            ex_ctrl      <= (flush || stall) ? ctrl_nop : id_ctrl;
            mem_ctrl     <= flush ? ctrl_nop : ex_ctrl;
            mem_br_taken <= br_taken && !flush;
            wb_ctrl      <= mem_ctrl;
        end
    end

    // payload follows the control words
    always_ff @(posedge clk) begin
        if (advance) begin
            if (!stall) begin
                if_pc <= pc;
            end
            ex_data  <= '{pc: if_pc, rs1_val: rs1_val, rs2_val: rs2_val};
            mem_data <= '{alu: alu_out, store_data: store_data, br_target: br_target};
            wb_data  <= '{alu: mem_data.alu, rdata: data_rdata};
        end
    end

    rv_decode u_decode (
        .instr (if_instr),
        .ctrl  (id_ctrl)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (wb_ctrl.load_regfile && advance),
        .rd     (wb_ctrl.rd),
        .wdata  (wb_val),
        .rs1    (id_ctrl.rs1),
        .rs2    (id_ctrl.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    rv_execute u_execute (
        .ctrl       (ex_ctrl),
        .pc         (ex_data.pc),
        .rs1_val    (ex_data.rs1_val),
        .rs2_val    (ex_data.rs2_val),
        .mem_val    (mem_val),
        .wb_val     (wb_val),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .alu_out    (alu_out),
        .store_data (store_data),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    rv_hazard u_hazard (
        .id_ctrl      (id_ctrl),
        .ex_ctrl      (ex_ctrl),
        .mem_ctrl     (mem_ctrl),
        .wb_ctrl      (wb_ctrl),
        .br_taken_mem (mem_br_taken),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .stall        (stall),
        .flush        (flush)
    );

    // lui in mem has its result in the immediate, not the alu
    assign mem_val = (mem_ctrl.wb_sel == wb_imm) ? mem_ctrl.imm : mem_data.alu;

    always_comb begin
        case (wb_ctrl.wb_sel)
            wb_mem:  wb_val = wb_data.rdata;
            wb_imm:  wb_val = wb_ctrl.imm;
            default: wb_val = wb_data.alu;
        endcase
    end

    assign inst_addr  = pc;
    assign data_addr  = mem_data.alu;
    assign data_wdata = mem_data.store_data;
    assign data_read  = mem_ctrl.mem_read;
    assign data_write = mem_ctrl.mem_write;

endmodule

/* test/rv_core_assert.sv */
`timescale 1ns/10ps

module rv_core_assert #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input logic          clk,
    input logic          arst_n,
    input rv_pkg::word_t inst_addr,
    input rv_pkg::word_t data_addr,
    input rv_pkg::word_t data_wdata,
    input logic          data_read,
    input logic          data_write,
    input logic          data_resp
);

    reset_state: assert property (@(posedge clk)
        !arst_n |=> (inst_addr == RESET_PC) && !data_read && !data_write)
        else $error("pc or data port not in reset state");

    one_access: assert property (@(posedge clk) disable iff (!arst_n)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    // a waiting request must not move
    hold_request: assert property (@(posedge clk) disable iff (!arst_n)
        (data_read || data_write) && !data_resp |=>
            $stable(data_addr) && $stable(data_wdata) &&
            $stable(data_read) && $stable(data_write))
        else $error("data request changed before data_resp");

endmodule

bind rv_core rv_core_assert #(
    .RESET_PC (RESET_PC)
) u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_addr  (inst_addr),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_read  (data_read),
    .data_write (data_write),
    .data_resp  (data_resp)
);

/* test/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    typedef struct packed {
        opcode_e    op;
        logic [2:0] f3;
        logic       alt;   // sub and sra select
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
    } ins_t;

    localparam word_t start_pc   = 32'h0;
    localparam int    body_len   = 190;
    localparam int    max_cycles = 20000;

    logic  clk       = 1'b0;
    logic  arst_n    = 1'b0;
    logic  inst_resp = 1'b0;
    logic  data_resp = 1'b0;
    word_t inst_rdata;
    word_t inst_addr;
    word_t data_rdata;
    word_t data_addr;
    word_t data_wdata;
    logic  data_read;
    logic  data_write;

    word_t imem [0:255];
    word_t dmem [0:63];   // data region at address 0
    ins_t  prog [0:255];
    int    n_ins;
    word_t end_addr;
    word_t lfsr = 32'h7514e14e;
    word_t exp_addr [$];
    word_t exp_data [$];

    rv_core #(
        .RESET_PC (start_pc)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .inst_addr  (inst_addr),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_read  (data_read),
        .data_write (data_write)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic word_t lfsr_step(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t any_reg();
        return reg_addr_t'(rand_bits(3));   // x0..x7
    endfunction

    function automatic reg_addr_t dest_reg();
        reg_addr_t r;
        r = reg_addr_t'(rand_bits(3));
        return (r == '0) ? 5'd7 : r;
    endfunction

    function automatic word_t encode(ins_t i);
        case (i.op)
            op_reg:   return {1'b0, i.alt, 5'b0, i.rs2, i.rs1, i.f3, i.rd, i.op};
            op_imm,
            op_load:  return {i.imm[11:0], i.rs1, i.f3, i.rd, i.op};
            op_lui:   return {i.imm[31:12], i.rd, i.op};
            op_store: return {i.imm[11:5], i.rs2, i.rs1, i.f3, i.imm[4:0], i.op};
            op_br:    return {i.imm[12], i.imm[10:5], i.rs2, i.rs1, i.f3,
                              i.imm[4:1], i.imm[11], i.op};
            default:  return '0;
        endcase
    endfunction

    function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic model_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic emit(ins_t i);
        prog[n_ins] = i;
        imem[n_ins] = encode(i);
        n_ins++;
    endtask

    task automatic gen_program();
        ins_t       i;
        logic [2:0] kind;
        logic [1:0] skip;
        logic [11:0] imm12;
        for (int a = 0; a < 256; a++) begin
            imem[a] = (word_t'(a) << 7) | 32'h7f;   // unknown opcode decodes as a bubble
        end
        for (int a = 0; a < 64; a++) begin
            dmem[a] = (word_t'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        n_ins = 0;
        while (n_ins < body_len) begin
            i     = '0;
            kind  = 3'(rand_bits(3));
            i.f3  = 3'(rand_bits(3));
            i.rd  = dest_reg();
            i.rs1 = any_reg();
            i.rs2 = any_reg();
            case (kind)
                3'd3: begin
                    i.op  = op_imm;
                    i.alt = (i.f3 == 3'b101) && 1'(rand_bits(1));
                    imm12 = 12'(rand_bits(12));
                    if (i.f3 == 3'b001 || i.f3 == 3'b101) begin
                        i.imm = {21'b0, i.alt, 5'b0, imm12[4:0]};
                    end else begin
                        i.imm = {{20{imm12[11]}}, imm12};
                    end
                end
                3'd4: begin
                    i.op  = op_lui;
                    i.imm = {20'(rand_bits(20)), 12'h000};
                end
                3'd5: begin
                    i.op  = op_load;
                    i.f3  = 3'b010;
                    i.rs1 = '0;
                    i.imm = {24'b0, 6'(rand_bits(6)), 2'b00};
                    emit(i);
                    // consumer right behind the load
                    i.op  = op_reg;
                    i.f3  = 3'b000;
                    i.alt = 1'(rand_bits(1));
                    i.rs1 = i.rd;
                    i.rd  = dest_reg();
                    i.imm = '0;
                end
                3'd6: begin
                    i.op  = op_store;
                    i.f3  = 3'b010;
                    i.rs1 = '0;
                    i.imm = {24'b0, 6'(rand_bits(6)), 2'b00};
                end
                3'd7: begin
                    i.op  = op_br;
                    i.f3  = {1'(rand_bits(1)), 1'b0, 1'(rand_bits(1))};
                    skip  = 2'(rand_bits(2));
                    if (skip == 2'd0) begin
                        skip = 2'd1;
                    end
                    i.imm = {27'b0, {1'b0, skip} + 3'd1, 2'b00};   // skips 1..3
                end
                default: begin
                    i.op  = op_reg;
                    i.alt = (i.f3 == 3'b000 || i.f3 == 3'b101) && 1'(rand_bits(1));
                end
            endcase
            emit(i);
        end
        // dump x1..x7 to the start of the data region
        for (int r = 1; r < 8; r++) begin
            i     = '0;
            i.op  = op_store;
            i.f3  = 3'b010;
            i.rs2 = reg_addr_t'(r);
            i.imm = word_t'((r - 1) * 4);
            emit(i);
        end
        end_addr = word_t'(n_ins * 4);
        i        = '0;
        i.op     = op_br;   // beq x0, x0, 0
        emit(i);
    endtask

    task automatic run_model();
        word_t x [0:31];
        word_t mem [0:63];
        ins_t  i;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        int    k;
        int    steps;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int r = 0; r < 64; r++) begin
            mem[r] = dmem[r];
        end
        k     = 0;
        steps = 0;
        while (word_t'(k * 4) != end_addr && steps < max_cycles) begin
            i    = prog[k];
            a    = x[i.rs1];
            b    = x[i.rs2];
            res  = '0;
            addr = a + i.imm;
            k++;
            steps++;
            case (i.op)
                op_reg:  res = model_alu(i.f3, i.alt, a, b);
                op_imm:  res = model_alu(i.f3, i.alt, a, i.imm);
                op_lui:  res = i.imm;
                op_load: res = mem[addr[7:2]];
                op_store: begin
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                op_br: begin
                    if (model_taken(i.f3, a, b)) begin
                        k = k - 1 + int'(i.imm >> 2);
                    end
                end
                default: res = '0;
            endcase
            if ((i.op inside {op_reg, op_imm, op_lui, op_load}) && i.rd != '0) begin
                x[i.rd] = res;
            end
        end
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    assign inst_rdata = imem[inst_addr[9:2]];
    assign data_rdata = data_read ? dmem[data_addr[7:2]] : '0;   // only a load gets data

    // both memories answer about three cycles in four
    always @(posedge clk) begin
        inst_resp <= rand_bits(2) != 0;
        data_resp <= rand_bits(2) != 0;
    end

    initial begin
        int    hits;
        int    n_seen;
        word_t prev_addr;
        gen_program();
        run_model();
        @(posedge clk);
        @(negedge clk);
        check_word(inst_addr, start_pc, "inst_addr under reset");
        check_level(data_read, 1'b0, "data_read under reset");
        check_level(data_write, 1'b0, "data_write under reset");
        @(posedge clk);
        arst_n <= 1'b1;

        hits      = 0;
        n_seen    = 0;
        prev_addr = inst_addr;
        for (int cyc = 0; cyc < max_cycles && hits < 2; cyc++) begin
            @(negedge clk);
            check_level(data_read && data_write, 1'b0, "data_read and data_write together");
            // a store commits when the whole pipeline moves
            if (data_write && data_resp && inst_resp) begin
                if (n_seen >= exp_addr.size()) begin
                    abort_run("the core stored more words than the model predicts");
                end else begin
                    check_word(data_addr, exp_addr[n_seen], "store address");
                    check_word(data_wdata, exp_data[n_seen], "store data");
                    dmem[data_addr[7:2]] = data_wdata;
                    n_seen++;
                end
            end
            if (inst_addr == end_addr && prev_addr != end_addr) begin
                hits++;   // second arrival means the spin branch resolved
            end
            prev_addr = inst_addr;
        end

        if (hits < 2) begin
            abort_run("timeout: the program never reached its final branch");
        end else if (n_seen != exp_addr.size()) begin
            abort_run($sformatf("the core stored %0d words, the model predicts %0d",
                                n_seen, exp_addr.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* project.f */
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_hazard.sv
hw/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell cat project.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): project.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
